// ==== intexp_consts.svh ====
/*
 * Constants for the interrupt and exception handler.
 * Include this file in any block that needs an IDT vector address or the
 * recovery sequence length.
 */
`ifndef INTEXP_CONSTS_SVH
`define INTEXP_CONSTS_SVH

// ##################################################
// IDT vector addresses
// ##################################################
`define INTEXP_VEC_INT  32'h0000_2010
`define INTEXP_VEC_PROT 32'h0000_2068
`define INTEXP_VEC_PAGE 32'h0000_2070

// Longest recovery microsequence, in ROM steps
`define INTEXP_SEQ_STEPS 4

`endif

// ==== pipe_pkg.sv ====
/*
 * Pipeline state as the interrupt handler sees it.
 * Covers stage valid bits, cache fault flags and CS:EIP far pointers.
 */
package pipe_pkg;

  typedef logic [31:0] eip_t;
  typedef logic [15:0] cs_t;
  typedef logic [31:0] idt_addr_t;

  // Segment selector in the upper 16 bits, offset in the lower 32
  typedef struct packed {
    cs_t  cs;
    eip_t eip;
  } far_ptr_t;

  // One valid bit per pipeline stage, decode through writeback
  typedef struct packed {
    logic de;
    logic ag;
    logic ro;
    logic ex;
    logic wb;
  } pipe_valid_t;

  // Data-cache flags come from the operand read stage
  typedef struct packed {
    logic dc_prot;
    logic dc_page;
    logic ic_prot;
    logic ic_page;
  } fault_t;

endpackage

// ==== intexp_pkg.sv ====
/*
 * Types private to the interrupt and exception handler.
 * Holds the FSM state encoding and the microsequence address pieces.
 */
package intexp_pkg;

  // ##################################################
  // Handler FSM
  // ##################################################
  typedef enum logic [2:0] {
    IDLE       = 3'd0,
    DRAIN      = 3'd1,
    EXC_SEQ    = 3'd2,
    IRET_DRAIN = 3'd3,
    IRET_SEQ   = 3'd4,
    CLEAR      = 3'd5
  } intexp_state_t;

  // ##################################################
  // Microsequence addressing
  // ##################################################

  // Selects which half of the recovery ROM is in use
  typedef enum logic {
    SEQ_EXC  = 1'b0,
    SEQ_IRET = 1'b1
  } seq_sel_t;

  typedef logic [1:0] rseq_step_t;

  // Selector in the top bit, step count below it
  typedef logic [2:0] rseq_addr_t;

endpackage

// ==== intexp_fsm.sv ====
/*
 * Control FSM of the interrupt and exception handler.
 * Orders event detection, pipeline drain, the recovery microsequence and
 * the final clear pulse, for both events and IRET.
 */
`timescale 1ns/100ps

module intexp_fsm (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  int_req,
  input  logic                  ic_exp,
  input  logic                  dc_exp,
  input  logic                  iret_op,
  input  pipe_pkg::pipe_valid_t pipe_valid,
  input  logic                  fifo_not_empty,
  input  logic                  ld_ro,
  input  logic                  end_bit,
  input  logic                  seq_last,
  output logic                  capture,
  output logic                  step,
  output logic                  seq_clear,
  output intexp_pkg::seq_sel_t  seq_sel,
  output logic                  rseq_mux_sel,
  output logic                  block_ic_ren,
  output logic                  int_clear
);
  import intexp_pkg::*;

  intexp_state_t state;
  intexp_state_t state_nxt;
  logic          event_req;
  logic          pipe_busy;
  logic          in_seq;
  logic          seq_done;

  assign event_req = int_req | ic_exp | dc_exp;

  // Anything still in flight keeps the handler waiting
  assign pipe_busy = pipe_valid.de | pipe_valid.ag | pipe_valid.ro |
                     pipe_valid.ex | pipe_valid.wb | fifo_not_empty;

  assign in_seq   = (state == EXC_SEQ) || (state == IRET_SEQ);
  assign seq_done = ld_ro & (end_bit | seq_last);

  // ##################################################
  // State register and next state
  // ##################################################
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        // Events win over an IRET seen in the same cycle
        if (event_req) begin
          state_nxt = DRAIN;
        end else if (iret_op) begin
          state_nxt = IRET_DRAIN;
        end
      end
      DRAIN: begin
        if (!pipe_busy) begin
          state_nxt = EXC_SEQ;
        end
      end
      IRET_DRAIN: begin
        if (!pipe_busy) begin
          state_nxt = IRET_SEQ;
        end
      end
      EXC_SEQ, IRET_SEQ: begin
        if (seq_done) begin
          state_nxt = CLEAR;
        end
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  // ##################################################
  // Output decode
  // ##################################################

  // Only capture and step look at the inputs directly
  assign capture = (state == IDLE) & event_req;
  assign step    = in_seq & ld_ro;

  assign seq_clear    = ~in_seq;
  assign seq_sel      = ((state == IRET_DRAIN) || (state == IRET_SEQ)) ? SEQ_IRET : SEQ_EXC;
  assign rseq_mux_sel = in_seq;
  assign block_ic_ren = (state != IDLE);
  assign int_clear    = (state == CLEAR);

endmodule

// ==== rseq_counter.sv ====
/*
 * Step counter for the recovery microsequence.
 * Builds the ROM address from the sequence selector and the step count.
 */
`timescale 1ns/100ps
`include "intexp_consts.svh"

module rseq_counter (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   step,
  input  logic                   seq_clear,
  input  intexp_pkg::seq_sel_t   seq_sel,
  output intexp_pkg::rseq_addr_t rseq_addr,
  output logic                   seq_last
);
  import intexp_pkg::*;

  rseq_step_t count;

  // Holds on the last step so a sequence without an end bit cannot wrap
  always_ff @(posedge clk) begin
    if (reset || seq_clear) begin
      count <= '0;
    end else if (step && !seq_last) begin
      count <= count + rseq_step_t'(1);
    end
  end

  assign seq_last = (count == rseq_step_t'(`INTEXP_SEQ_STEPS - 1));

  assign rseq_addr = {seq_sel, count};

endmodule

// ==== fault_capture.sv ====
/*
 * Vector and return pointer capture for interrupts and exceptions.
 * Picks the IDT address by fault priority and the CS:EIP of the stage that
 * took the event, then holds both from one capture to the next.
 */
`timescale 1ns/100ps
`include "intexp_consts.svh"

module fault_capture (
  input  logic                clk,
  input  logic                reset,
  input  logic                capture,
  input  pipe_pkg::fault_t    fault,
  input  logic                dc_exp,
  input  pipe_pkg::far_ptr_t  cur_ptr,
  input  pipe_pkg::far_ptr_t  ro_ptr,
  output pipe_pkg::idt_addr_t idt_addr,
  output pipe_pkg::far_ptr_t  saved_ptr
);
  import pipe_pkg::*;

  idt_addr_t vec_sel;
  far_ptr_t  ptr_sel;

  // ##################################################
  // Vector priority
  // ##################################################

  // Data faults are older in program order than fetch faults
  always_comb begin
    if (fault.dc_prot) begin
      vec_sel = `INTEXP_VEC_PROT;
    end else if (fault.dc_page) begin
      vec_sel = `INTEXP_VEC_PAGE;
    end else if (fault.ic_prot) begin
      vec_sel = `INTEXP_VEC_PROT;
    end else if (fault.ic_page) begin
      vec_sel = `INTEXP_VEC_PAGE;
    end else begin
      vec_sel = `INTEXP_VEC_INT;
    end
  end

  // A data fault returns to the instruction in operand read
  assign ptr_sel = dc_exp ? ro_ptr : cur_ptr;

  always_ff @(posedge clk) begin
    if (reset) begin
      idt_addr  <= '0;
      saved_ptr <= '0;
    end else if (capture) begin
      idt_addr  <= vec_sel;
      saved_ptr <= ptr_sel;
    end
  end

endmodule

// ==== intexp.sv ====
/*
 * Interrupt and exception handler top level.
 * Joins the control FSM, the microsequence step counter and the
 * vector and pointer capture.
 */
`timescale 1ns/100ps

module intexp (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   int_req,
  input  logic                   ic_exp,
  input  logic                   dc_exp,
  input  logic                   iret_op,
  input  pipe_pkg::pipe_valid_t  pipe_valid,
  input  logic                   fifo_not_empty,
  input  logic                   ld_ro,
  input  logic                   end_bit,
  input  pipe_pkg::fault_t       fault,
  input  pipe_pkg::far_ptr_t     cur_ptr,
  input  pipe_pkg::far_ptr_t     ro_ptr,
  output pipe_pkg::idt_addr_t    idt_addr,
  output pipe_pkg::far_ptr_t     saved_ptr,
  output intexp_pkg::rseq_addr_t rseq_addr,
  output logic                   rseq_mux_sel,
  output logic                   block_ic_ren,
  output logic                   int_clear
);
  import intexp_pkg::*;

  logic     capture;
  logic     step;
  logic     seq_clear;
  logic     seq_last;
  seq_sel_t seq_sel;

  intexp_fsm u_fsm (
    .clk            (clk),
    .reset          (reset),
    .int_req        (int_req),
    .ic_exp         (ic_exp),
    .dc_exp         (dc_exp),
    .iret_op        (iret_op),
    .pipe_valid     (pipe_valid),
    .fifo_not_empty (fifo_not_empty),
    .ld_ro          (ld_ro),
    .end_bit        (end_bit),
    .seq_last       (seq_last),
    .capture        (capture),
    .step           (step),
    .seq_clear      (seq_clear),
    .seq_sel        (seq_sel),
    .rseq_mux_sel   (rseq_mux_sel),
    .block_ic_ren   (block_ic_ren),
    .int_clear      (int_clear)
  );

  rseq_counter u_rseq_counter (
    .clk       (clk),
    .reset     (reset),
    .step      (step),
    .seq_clear (seq_clear),
    .seq_sel   (seq_sel),
    .rseq_addr (rseq_addr),
    .seq_last  (seq_last)
  );

  fault_capture u_fault_capture (
    .clk       (clk),
    .reset     (reset),
    .capture   (capture),
    .fault     (fault),
    .dc_exp    (dc_exp),
    .cur_ptr   (cur_ptr),
    .ro_ptr    (ro_ptr),
    .idt_addr  (idt_addr),
    .saved_ptr (saved_ptr)
  );

endmodule

// ==== tb_intexp.sv ====
/*
 * Directed testbench for the interrupt and exception handler.
 * Plays the pipeline and microcode ROM by driving strobes and levels on the
 * falling clock edge, and checks outputs on the falling edge as well.
 */
`timescale 1ns/100ps
`include "intexp_consts.svh"

module tb_intexp;
  import pipe_pkg::*;
  import intexp_pkg::*;

  logic        clk;
  logic        reset;
  logic        int_req;
  logic        ic_exp;
  logic        dc_exp;
  logic        iret_op;
  pipe_valid_t pipe_valid;
  logic        fifo_not_empty;
  logic        ld_ro;
  logic        end_bit;
  fault_t      fault;
  far_ptr_t    cur_ptr;
  far_ptr_t    ro_ptr;
  idt_addr_t   idt_addr;
  far_ptr_t    saved_ptr;
  rseq_addr_t  rseq_addr;
  logic        rseq_mux_sel;
  logic        block_ic_ren;
  logic        int_clear;
  logic [31:0] rng_state;

  intexp uut (.*);

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // ##################################################
  // Helpers
  // ##################################################
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "Simulation stopped on the first failure");
  endtask

  task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else
      stop_run($sformatf("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp));
  endtask

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Fault priority runs dc_prot, dc_page, ic_prot, ic_page, then interrupt
  function automatic idt_addr_t expected_vector(input fault_t f);
    if (f.dc_prot) return `INTEXP_VEC_PROT;
    if (f.dc_page) return `INTEXP_VEC_PAGE;
    if (f.ic_prot) return `INTEXP_VEC_PROT;
    if (f.ic_page) return `INTEXP_VEC_PAGE;
    return `INTEXP_VEC_INT;
  endfunction

  // Holds the event levels for one cycle, as a pipeline stage would
  task automatic raise_event(input logic irq, input logic ic, input logic dc, input fault_t f,
                             input far_ptr_t cur, input far_ptr_t ro);
    int_req = irq;
    ic_exp  = ic;
    dc_exp  = dc;
    fault   = f;
    cur_ptr = cur;
    ro_ptr  = ro;
    @(negedge clk);
    int_req = 1'b0;
    ic_exp  = 1'b0;
    dc_exp  = 1'b0;
    fault   = '0;
    check_eq("block_ic_ren after event", 64'(block_ic_ren), 64'd1);
  endtask

  task automatic await_seq_start(input int limit);
    int waited;
    waited = 0;
    while (!rseq_mux_sel) begin
      if (waited >= limit) stop_run("Timeout: rseq_mux_sel never rose after the drain");
      @(negedge clk);
      waited++;
    end
  endtask

  task automatic strobe_rom(input logic eb);
    ld_ro   = 1'b1;
    end_bit = eb;
    @(negedge clk);
    ld_ro   = 1'b0;
    end_bit = 1'b0;
  endtask

  task automatic expect_clear_pulse();
    check_eq("int_clear in CLEAR", 64'(int_clear), 64'd1);
    check_eq("block_ic_ren in CLEAR", 64'(block_ic_ren), 64'd1);
    @(negedge clk);
    check_eq("int_clear after CLEAR", 64'(int_clear), 64'd0);
    check_eq("block_ic_ren after CLEAR", 64'(block_ic_ren), 64'd0);
    check_eq("rseq_mux_sel after CLEAR", 64'(rseq_mux_sel), 64'd0);
  endtask

  task automatic finish_sequence();
    await_seq_start(20);
    check_eq("rseq_addr at exception sequence start", 64'(rseq_addr), 64'd0);
    strobe_rom(1'b1);
    expect_clear_pulse();
  endtask

  // ##################################################
  // Directed tests
  // ##################################################
  task automatic check_reset_state();
    check_eq("int_clear", 64'(int_clear), 64'd0);
    check_eq("block_ic_ren", 64'(block_ic_ren), 64'd0);
    check_eq("rseq_mux_sel", 64'(rseq_mux_sel), 64'd0);
    check_eq("rseq_addr", 64'(rseq_addr), 64'd0);
    check_eq("idt_addr", 64'(idt_addr), 64'd0);
    check_eq("saved_ptr", 64'(saved_ptr), 64'd0);
  endtask

  task automatic run_interrupt_path();
    far_ptr_t cur;
    cur = {16'h0008, 32'h0040_1000};
    raise_event(1'b1, 1'b0, 1'b0, '0, cur, '0);
    check_eq("idt_addr for interrupt", 64'(idt_addr), 64'(`INTEXP_VEC_INT));
    check_eq("saved_ptr for interrupt", 64'(saved_ptr), 64'(cur));
    await_seq_start(20);
    for (int i = 0; i < 3; i++) begin
      check_eq("rseq_addr in exception sequence", 64'(rseq_addr), 64'(i));
      strobe_rom(i == 2);
    end
    expect_clear_pulse();
  endtask

  task automatic run_data_faults();
    far_ptr_t cur;
    far_ptr_t ro;
    cur = {16'h0010, 32'h0000_8000};
    ro  = {16'h0018, 32'h0000_7ff4};
    raise_event(1'b0, 1'b0, 1'b1, fault_t'(4'b0100), cur, ro);
    check_eq("idt_addr for page fault", 64'(idt_addr), 64'(`INTEXP_VEC_PAGE));
    check_eq("saved_ptr for data fault", 64'(saved_ptr), 64'(ro));
    finish_sequence();
    // dc_prot must win over ic_page raised in the same cycle
    // An IRET seen together with the event has to wait behind it
    iret_op = 1'b1;
    raise_event(1'b0, 1'b1, 1'b1, fault_t'(4'b1001), cur, ro);
    iret_op = 1'b0;
    check_eq("idt_addr for dc_prot over ic_page", 64'(idt_addr), 64'(`INTEXP_VEC_PROT));
    finish_sequence();
  endtask

  task automatic run_drain_backpressure();
    int hold;
    raise_event(1'b1, 1'b0, 1'b0, '0, '0, '0);
    // Each stage on its own must hold off the sequence
    for (int b = 0; b < 5; b++) begin
      pipe_valid = pipe_valid_t'(5'b00001 << b);
      hold       = 1 + int'(next_rand() % 32'd4);
      repeat (hold) begin
        check_eq("block_ic_ren while draining", 64'(block_ic_ren), 64'd1);
        check_eq("rseq_mux_sel while draining", 64'(rseq_mux_sel), 64'd0);
        @(negedge clk);
      end
    end
    // The FIFO alone still holds off the sequence
    pipe_valid     = '0;
    fifo_not_empty = 1'b1;
    @(negedge clk);
    check_eq("rseq_mux_sel with FIFO busy", 64'(rseq_mux_sel), 64'd0);
    fifo_not_empty = 1'b0;
    finish_sequence();
  endtask

  task automatic run_iret();
    iret_op = 1'b1;
    @(negedge clk);
    iret_op = 1'b0;
    check_eq("block_ic_ren in IRET drain", 64'(block_ic_ren), 64'd1);
    await_seq_start(20);
    for (int i = 0; i < 4; i++) begin
      check_eq("rseq_addr in IRET sequence", 64'(rseq_addr), 64'(4 + i));
      strobe_rom(1'b0);
    end
    expect_clear_pulse();
  endtask

  task automatic run_random_events();
    logic [31:0] r;
    far_ptr_t    cur;
    far_ptr_t    ro;
    for (int n = 0; n < 8; n++) begin
      r   = next_rand();
      cur = {r[31:16], next_rand()};
      ro  = {r[15:0], next_rand()};
      raise_event(~r[4] & ~r[5], r[5], r[4], fault_t'(r[3:0]), cur, ro);
      check_eq("idt_addr for random event", 64'(idt_addr), 64'(expected_vector(fault_t'(r[3:0]))));
      check_eq("saved_ptr for random event", 64'(saved_ptr), 64'(r[4] ? ro : cur));
      finish_sequence();
    end
  endtask

  initial begin
    rng_state      = 32'h56dbcb56;
    reset          = 1'b1;
    int_req        = 1'b0;
    ic_exp         = 1'b0;
    dc_exp         = 1'b0;
    iret_op        = 1'b0;
    pipe_valid     = '0;
    fifo_not_empty = 1'b0;
    ld_ro          = 1'b0;
    end_bit        = 1'b0;
    fault          = '0;
    cur_ptr        = '0;
    ro_ptr         = '0;
    repeat (3) @(negedge clk);
    reset = 1'b0;
    check_reset_state();
    run_interrupt_path();
    run_data_faults();
    run_drain_backpressure();
    run_iret();
    run_random_events();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+.
pipe_pkg.sv
intexp_pkg.sv
intexp_fsm.sv
rseq_counter.sv
fault_capture.sv
intexp.sv
tb_intexp.sv

// ==== Makefile ====
# Verilator build for the interrupt and exception handler testbench
TOP = tb_intexp

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f -o Vtb_intexp

# A failing check ends in $fatal, so the binary exits non-zero
run: compile
	./obj_dir/Vtb_intexp

clean:
	rm -rf obj_dir
